//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // 16-bit byte address space
    typedef logic [15:0] addr_t;

    // One cache line worth of data
    typedef logic [63:0] mem_block_t;

    // Zero means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_LOAD = 2'd1
    } mem_command_t;

endpackage

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    import mem_pkg::*;

    // Direct-mapped geometry, 8-byte lines
    localparam int CACHE_LINE_BITS = 5;
    localparam int CACHE_LINES     = 32;
    localparam int CACHE_TAG_BITS  = 8;

    typedef logic [CACHE_LINE_BITS-1:0] cache_index_t;
    typedef logic [CACHE_TAG_BITS-1:0]  cache_tag_t;

    // Same 16 bits seen flat or split into tag, index and offset
    typedef union packed {
        addr_t addr;
        struct packed {
            cache_tag_t   tag;
            cache_index_t index;
            logic [2:0]   offset;
        } fields;
    } fetch_addr_t;

    typedef enum logic [1:0] {
        INVALID   = 2'd0,
        PENDING   = 2'd1,
        WAIT_TAG  = 2'd2,
        WAIT_DATA = 2'd3
    } imshr_state_t;

endpackage

`default_nettype wire

//--- rtl/psel_gen.sv
`timescale 1ns/1ps
`default_nettype none

module psel_gen #(
    parameter int WIDTH = 4,
    parameter int REQS  = 1
) (
    input  wire  [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    logic [WIDTH-1:0] remaining;

    // Peel off the lowest set bit once per grant row
    always_comb begin
        remaining = req;
        for (int r = 0; r < REQS; r++) begin
            gnt_bus[r] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[r];
        end
    end

    always_comb begin
        gnt = '0;
        for (int r = 0; r < REQS; r++) begin
            gnt = gnt | gnt_bus[r];
        end
    end

    assign empty = ~|req;

endmodule

`default_nettype wire

//--- rtl/imshr.sv
`timescale 1ns/1ps
`default_nettype none

module imshr
    import mem_pkg::*;
    import cache_pkg::*;
#(
    parameter int N            = 2,
    parameter int MSHR_ENTRIES = 4
) (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         squash,
    input  wire                         dcache_request,
    input  wire mem_tag_t               mem2proc_transaction_tag,
    input  wire mem_tag_t               mem2proc_data_tag,
    input  wire [N-1:0]                 miss_valid,
    input  wire cache_index_t [N-1:0]   miss_index,
    input  wire cache_tag_t [N-1:0]     miss_tag,
    output addr_t                       proc2mem_addr,
    output mem_command_t                proc2mem_command,
    output logic                        fill_valid,
    output cache_index_t                fill_index,
    output cache_tag_t                  fill_tag
);

    imshr_state_t state_q    [MSHR_ENTRIES];
    imshr_state_t state_next [MSHR_ENTRIES];
    cache_index_t index_q    [MSHR_ENTRIES];
    cache_index_t index_next [MSHR_ENTRIES];
    cache_tag_t   tag_q      [MSHR_ENTRIES];
    cache_tag_t   tag_next   [MSHR_ENTRIES];
    mem_tag_t     txn_q      [MSHR_ENTRIES];
    mem_tag_t     txn_next   [MSHR_ENTRIES];

    logic [MSHR_ENTRIES-1:0]        entry_free;
    logic [MSHR_ENTRIES-1:0]        entry_pending;
    logic [MSHR_ENTRIES-1:0]        entry_wait_tag;
    logic [N-1:0][MSHR_ENTRIES-1:0] free_gnt_bus;
    logic [MSHR_ENTRIES-1:0]        issue_gnt;
    logic                           issue_empty;
    logic                           issue_ok;
    logic [N-1:0]                   miss_merged;
    fetch_addr_t                    load_addr;

    always_comb begin
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            entry_free[e]     = state_q[e] == INVALID;
            entry_pending[e]  = state_q[e] == PENDING;
            entry_wait_tag[e] = state_q[e] == WAIT_TAG;
        end
    end

    psel_gen #(
        .WIDTH (MSHR_ENTRIES),
        .REQS  (N)
    ) u_free_sel (
        .req     (entry_free),
        .gnt     (),
        .gnt_bus (free_gnt_bus),
        .empty   ()
    );

    psel_gen #(
        .WIDTH (MSHR_ENTRIES),
        .REQS  (1)
    ) u_issue_sel (
        .req     (entry_pending),
        .gnt     (issue_gnt),
        .gnt_bus (),
        .empty   (issue_empty)
    );

    // Only one load per tag window, so no issue while a tag is awaited
    assign issue_ok = !issue_empty && !dcache_request && !squash && !(|entry_wait_tag);

    // Drop misses already tracked or repeated by an earlier port
    always_comb begin
        for (int i = 0; i < N; i++) begin
            miss_merged[i] = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (miss_valid[j] && miss_index[j] == miss_index[i] && miss_tag[j] == miss_tag[i])
                    miss_merged[i] = 1'b1;
            end
            for (int e = 0; e < MSHR_ENTRIES; e++) begin
                if (state_q[e] != INVALID && index_q[e] == miss_index[i] && tag_q[e] == miss_tag[i])
                    miss_merged[i] = 1'b1;
            end
        end
    end

    always_comb begin
        int slot;
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            state_next[e] = state_q[e];
            index_next[e] = index_q[e];
            tag_next[e]   = tag_q[e];
            txn_next[e]   = txn_q[e];
        end

        fill_valid = 1'b0;
        fill_index = '0;
        fill_tag   = '0;
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            if (state_q[e] == WAIT_DATA && mem2proc_data_tag != '0 && txn_q[e] == mem2proc_data_tag) begin
                fill_valid    = 1'b1;
                fill_index    = index_q[e];
                fill_tag      = tag_q[e];
                state_next[e] = INVALID;
            end
        end

        // A zero tag means memory refused, so retry later
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            if (state_q[e] == WAIT_TAG) begin
                txn_next[e]   = mem2proc_transaction_tag;
                state_next[e] = (mem2proc_transaction_tag == '0) ? PENDING : WAIT_DATA;
            end
        end

        load_addr        = '0;
        proc2mem_command = MEM_NONE;
        if (issue_ok) begin
            proc2mem_command = MEM_LOAD;
            for (int e = 0; e < MSHR_ENTRIES; e++) begin
                if (issue_gnt[e]) begin
                    load_addr.fields.tag   = tag_q[e];
                    load_addr.fields.index = index_q[e];
                    state_next[e]          = WAIT_TAG;
                end
            end
        end

        // Each new miss takes the next free entry in order
        slot = 0;
        for (int i = 0; i < N; i++) begin
            if (miss_valid[i] && !miss_merged[i]) begin
                for (int e = 0; e < MSHR_ENTRIES; e++) begin
                    if (free_gnt_bus[slot][e]) begin
                        state_next[e] = PENDING;
                        index_next[e] = miss_index[i];
                        tag_next[e]   = miss_tag[i];
                    end
                end
                slot++;
            end
        end
    end

    assign proc2mem_addr = load_addr.addr;

    always_ff @(posedge clock) begin
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            if (reset || squash) begin
                state_q[e] <= INVALID;
            end else begin
                state_q[e] <= state_next[e];
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int e = 0; e < MSHR_ENTRIES; e++) begin
            index_q[e] <= index_next[e];
            tag_q[e]   <= tag_next[e];
            txn_q[e]   <= txn_next[e];
        end
    end

endmodule

`default_nettype wire

//--- rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache
    import mem_pkg::*;
    import cache_pkg::*;
#(
    parameter int N            = 2,
    parameter int MSHR_ENTRIES = 4
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     squash,
    input  wire                     dcache_request,
    input  wire addr_t [N-1:0]      proc2icache_addr,
    input  wire [N-1:0]             valid,
    output mem_block_t [N-1:0]      icache_data_out,
    output logic [N-1:0]            icache_valid_out,
    output mem_command_t            proc2mem_command,
    output addr_t                   proc2mem_addr,
    input  wire mem_tag_t           mem2proc_transaction_tag,
    input  wire mem_block_t         mem2proc_data,
    input  wire mem_tag_t           mem2proc_data_tag
);

    logic [CACHE_LINES-1:0] line_valid;
    cache_tag_t             line_tag  [CACHE_LINES];
    mem_block_t             line_data [CACHE_LINES];

    fetch_addr_t [N-1:0]    fetch_addr;
    logic [N-1:0]           hit;
    logic [N-1:0]           miss_valid;
    cache_index_t [N-1:0]   miss_index;
    cache_tag_t [N-1:0]     miss_tag;

    logic                   fill_valid;
    cache_index_t           fill_index;
    cache_tag_t             fill_tag;

    // Per-port lookup, answered in the same cycle
    always_comb begin
        for (int i = 0; i < N; i++) begin
            fetch_addr[i]       = proc2icache_addr[i];
            miss_index[i]       = fetch_addr[i].fields.index;
            miss_tag[i]         = fetch_addr[i].fields.tag;
            hit[i]              = valid[i] && line_valid[miss_index[i]]
                                  && line_tag[miss_index[i]] == miss_tag[i];
            miss_valid[i]       = valid[i] && !hit[i];
            icache_valid_out[i] = hit[i];
            icache_data_out[i]  = hit[i] ? line_data[miss_index[i]] : '0;
        end
    end

    imshr #(
        .N            (N),
        .MSHR_ENTRIES (MSHR_ENTRIES)
    ) u_imshr (
        .clock                    (clock),
        .reset                    (reset),
        .squash                   (squash),
        .dcache_request           (dcache_request),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .miss_valid               (miss_valid),
        .miss_index               (miss_index),
        .miss_tag                 (miss_tag),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_command         (proc2mem_command),
        .fill_valid               (fill_valid),
        .fill_index               (fill_index),
        .fill_tag                 (fill_tag)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // Block comes straight off the memory data bus in the fill cycle
    always_ff @(posedge clock) begin
        if (fill_valid) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= mem2proc_data;
        end
    end

endmodule

`default_nettype wire

//--- dv/icache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module icache_assert
    import mem_pkg::*;
(
    input wire               clock,
    input wire               reset,
    input wire               dcache_request,
    input wire mem_command_t proc2mem_command
);

    int unsigned failures = 0;

    // Data cache owns the memory port in its cycle
    property p_dcache_priority;
        @(posedge clock) disable iff (reset)
        dcache_request |-> proc2mem_command != MEM_LOAD;
    endproperty

    // Tag window follows every load
    property p_no_back_to_back;
        @(posedge clock) disable iff (reset)
        proc2mem_command == MEM_LOAD |=> proc2mem_command != MEM_LOAD;
    endproperty

    property p_idle_after_reset;
        @(posedge clock)
        reset |=> proc2mem_command == MEM_NONE;
    endproperty

    a_dcache_priority: assert property (p_dcache_priority)
        else begin
            failures++;
            $error("load issued while dcache_request is high");
        end

    a_no_back_to_back: assert property (p_no_back_to_back)
        else begin
            failures++;
            $error("loads issued in two consecutive cycles");
        end

    a_idle_after_reset: assert property (p_idle_after_reset)
        else begin
            failures++;
            $error("memory command not idle after reset");
        end

endmodule

bind imshr icache_assert u_assert (
    .clock            (clock),
    .reset            (reset),
    .dcache_request   (dcache_request),
    .proc2mem_command (proc2mem_command)
);

`default_nettype wire

//--- dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import mem_pkg::*;
();

    localparam int CLOCK_PERIOD   = 100;
    localparam int DRIVE_DELAY    = 1;
    localparam int SAMPLE_DELAY   = 40;
    localparam int RESET_CYCLES   = 3;
    localparam int WATCHDOG_SLACK = 50;
    localparam int FIELDS         = 7;
    localparam int MAX_LINES      = 64;
    localparam int MAX_CYCLES     = 256;
    localparam int MIN_LATENCY    = 3;
    localparam int LATENCY_SPAN   = 4;

    logic             clock;
    logic             reset;
    logic             squash;
    logic             dcache_request;
    logic [1:0]       valid;
    addr_t [1:0]      fetch_addr;
    mem_block_t [1:0] icache_data_out;
    logic [1:0]       icache_valid_out;
    mem_command_t     proc2mem_command;
    addr_t            proc2mem_addr;
    mem_tag_t         mem2proc_transaction_tag;
    mem_block_t       mem2proc_data;
    mem_tag_t         mem2proc_data_tag;

    logic [15:0]      trace_mem [FIELDS*MAX_LINES];
    int               trace_len;
    logic [1:0]       trace_mask;

    // Reference cache contents
    logic             model_valid [32];
    logic [7:0]       model_tag   [32];
    bit               line_missed [8192];
    logic             seen_miss;

    // Memory model state, indexed by transaction tag
    logic             ld_live    [16];
    addr_t            ld_line    [16];
    mem_tag_t         next_txn;
    mem_tag_t         tag_due;
    mem_tag_t         ret_tag  [MAX_CYCLES];
    mem_block_t       ret_data [MAX_CYCLES];
    integer           seed;

    icache #(
        .N            (2),
        .MSHR_ENTRIES (4)
    ) u_dut (
        .clock                    (clock),
        .reset                    (reset),
        .squash                   (squash),
        .dcache_request           (dcache_request),
        .proc2icache_addr         (fetch_addr),
        .valid                    (valid),
        .icache_data_out          (icache_data_out),
        .icache_valid_out         (icache_valid_out),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data            (mem2proc_data),
        .mem2proc_data_tag        (mem2proc_data_tag)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD/2) clock = ~clock;

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic load_trace();
        for (int w = 0; w < FIELDS*MAX_LINES; w++) begin
            trace_mem[w] = 16'hffff;
        end
        $readmemh("dv/icache_trace.txt", trace_mem);
        trace_len = 0;
        while (trace_len < MAX_LINES && trace_mem[trace_len*FIELDS] != 16'hffff) begin
            trace_len++;
        end
        if (trace_len == 0)
            report_error("trace file is empty or missing");
    endtask

    task automatic drive_cycle(input int t);
        int base;
        base                     = t * FIELDS;
        valid[0]                 = trace_mem[base][0];
        valid[1]                 = trace_mem[base+1][0];
        fetch_addr[0]            = trace_mem[base+2];
        fetch_addr[1]            = trace_mem[base+3];
        dcache_request           = trace_mem[base+4][0];
        squash                   = trace_mem[base+5][0];
        trace_mask               = trace_mem[base+6][1:0];
        mem2proc_transaction_tag = tag_due;
        mem2proc_data_tag        = ret_tag[t];
        mem2proc_data            = ret_data[t];
    endtask

    task automatic check_fetch();
        addr_t      line;
        logic [4:0] index;
        logic [7:0] tag;
        logic [1:0] expected_hit;
        for (int i = 0; i < 2; i++) begin
            line            = fetch_addr[i] & 16'hfff8;
            index           = fetch_addr[i][7:3];
            tag             = fetch_addr[i][15:8];
            expected_hit[i] = valid[i] && model_valid[index] && model_tag[index] == tag;
            check_value($sformatf("icache_valid_out[%0d]", i), expected_hit[i],
                        icache_valid_out[i]);
            if (expected_hit[i])
                check_value($sformatf("icache_data_out[%0d]", i), {4{line}},
                            icache_data_out[i]);
        end
        check_value("trace hit mask", trace_mask, expected_hit);
        if (!seen_miss)
            check_value("proc2mem_command", MEM_NONE, proc2mem_command);
        for (int i = 0; i < 2; i++) begin
            if (valid[i] && !expected_hit[i]) begin
                line_missed[fetch_addr[i][15:3]] = 1'b1;
                seen_miss                        = 1'b1;
            end
        end
    endtask

    task automatic serve_memory(input int t);
        mem_tag_t txn;
        int       slot;
        tag_due = '0;
        if (proc2mem_command == MEM_LOAD) begin
            if (dcache_request)
                report_error("load issued while dcache_request is high");
            if (proc2mem_addr[2:0] != 3'b000)
                report_error("load address is not line-aligned");
            if (!line_missed[proc2mem_addr[15:3]])
                report_error("load issued for a line that never missed");
            for (int k = 1; k < 16; k++) begin
                if (ld_live[k] && ld_line[k] == proc2mem_addr)
                    report_error("second load in flight for the same line");
            end
            txn          = next_txn;
            next_txn     = (next_txn == 4'd15) ? 4'd1 : next_txn + 4'd1;
            ld_live[txn] = 1'b1;
            ld_line[txn] = proc2mem_addr;
            tag_due      = txn;
            slot = t + MIN_LATENCY + ({$random(seed)} % LATENCY_SPAN);
            // One data return per cycle
            while (slot < MAX_CYCLES && ret_tag[slot] != '0) begin
                slot++;
            end
            if (slot >= MAX_CYCLES)
                report_error("memory return schedule ran out of cycles");
            ret_tag[slot]  = txn;
            ret_data[slot] = {4{proc2mem_addr}};
        end else if (proc2mem_command !== MEM_NONE) begin
            report_error("memory command is neither MEM_NONE nor MEM_LOAD");
        end

        // Fill lands at the end of the data cycle unless squashed earlier
        if (ret_tag[t] != '0) begin
            txn = ret_tag[t];
            if (ld_live[txn]) begin
                model_valid[ld_line[txn][7:3]] = 1'b1;
                model_tag[ld_line[txn][7:3]]   = ld_line[txn][15:8];
            end
            ld_live[txn] = 1'b0;
        end
        if (squash) begin
            for (int k = 0; k < 16; k++) begin
                ld_live[k] = 1'b0;
            end
        end
    endtask

    initial begin
        seed                     = 90293;
        reset                    = 1'b1;
        squash                   = 1'b0;
        dcache_request           = 1'b0;
        valid                    = '0;
        fetch_addr               = '0;
        mem2proc_transaction_tag = '0;
        mem2proc_data            = '0;
        mem2proc_data_tag        = '0;
        trace_mask               = '0;
        seen_miss                = 1'b0;
        next_txn                 = 4'd1;
        tag_due                  = '0;
        for (int i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        for (int k = 0; k < 16; k++) begin
            ld_live[k] = 1'b0;
            ld_line[k] = '0;
        end
        for (int c = 0; c < MAX_CYCLES; c++) begin
            ret_tag[c]  = '0;
            ret_data[c] = '0;
        end
        load_trace();

        repeat (RESET_CYCLES) @(posedge clock);
        for (int t = 0; t < trace_len; t++) begin
            #(DRIVE_DELAY);
            reset = 1'b0;
            drive_cycle(t);
            #(SAMPLE_DELAY);
            if (u_dut.u_imshr.u_assert.failures != 0)
                report_error("a memory protocol assertion failed");
            check_fetch();
            serve_memory(t);
            @(posedge clock);
        end

        // Assertions sampled at the last edge report after it
        #(DRIVE_DELAY);
        if (u_dut.u_imshr.u_assert.failures == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_error("a memory protocol assertion failed");
        end
    end

    initial begin
        #(DRIVE_DELAY);
        #((RESET_CYCLES + trace_len + WATCHDOG_SLACK) * CLOCK_PERIOD);
        report_error("watchdog timeout, the run did not reach its end in time");
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/mem_pkg.sv
rtl/cache_pkg.sv
rtl/psel_gen.sv
rtl/imshr.sv
rtl/icache.sv
dv/icache_assert.sv
dv/icache_tb.sv

//--- Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
RTL_TOP   ?= icache
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no pass report in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/icache_trace.txt
// valid0 valid1 addr0 addr1 dcache_request squash hit_mask, hex, one cycle per line
// hit_mask bit 0 is port 0 and bit 1 is port 1
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
1 1 1000 1004 0 0 0
1 0 1002 0000 0 0 0
0 1 0000 1008 0 0 0
0 0 0000 0000 0 0 0
1 0 1010 0000 0 0 0
1 0 1012 0000 1 0 0
0 0 0000 0000 1 0 0
0 0 0000 0000 1 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
1 1 1000 1008 0 0 3
1 1 1006 100c 0 0 3
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
1 0 1014 0000 0 0 1
0 1 0000 3018 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 1 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 1 0000 3018 0 0 0
0 0 0000 0000 0 0 0
1 0 2000 0000 0 0 0
0 0 0000 0000 0 0 0
1 0 1000 0000 0 0 1
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
0 0 0000 0000 0 0 0
1 1 2004 301c 0 0 3
1 1 1000 1008 0 0 2
